/* all.f */
hdl/vector_pkg.sv
hdl/clip_pkg.sv
hdl/object_fetch.sv
hdl/line_fifo.sv
hdl/seq_divider.sv
hdl/clip_engine.sv
hdl/clip_unit.sv
testbench/clip_unit_assert.sv
testbench/tb_clip_unit.sv

/* Makefile */
TOP = tb_clip_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal -f all.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_clip_unit.sv */
`timescale 1ns/1ps

module tb_clip_unit import vector_pkg::*; ();

    localparam coord_t X_MAX   = 640;
    localparam coord_t Y_MAX   = 480;
    // 5 scans of 32 slots with up to 4 lines of 40 cycles per slot
    localparam int     TIMEOUT = 5 * NUM_SLOTS * (1 + 4 * 40) + 2000;

    typedef enum {EXPECT_EXACT, EXPECT_NONE, EXPECT_CLIPPED} expect_e;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    logic [NUM_SLOTS-1:0] obj_map;
    slot_t                mem_addr;
    logic                 mem_rd;
    obj_t                 obj;
    line_t                line_out;
    logic                 line_vld;
    logic                 busy;

    obj_t                 obj_mem [NUM_SLOTS];
    line_t                exp_q [$];   // exact lines or source lines when clipping
    expect_e              mode;
    int                   cycles;
    logic [NUM_SLOTS-1:0] map;

    clip_unit #(
        .X_MAX      (X_MAX),
        .Y_MAX      (Y_MAX),
        .FIFO_DEPTH (16)
    ) clip_unit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .obj_map  (obj_map),
        .mem_addr (mem_addr),
        .mem_rd   (mem_rd),
        .obj      (obj),
        .line_out (line_out),
        .line_vld (line_vld),
        .busy     (busy)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("Error at %0t: %s", $time, why);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic mismatch(input string name, input logic [71:0] got, input logic [71:0] want);
        $display("Fail at %0t: %s got %h, expected %h", $time, name, got, want);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic coord_t rand_coord(input int lo, input int hi);
        return coord_t'(lo + int'($urandom % (hi - lo + 1)));
    endfunction

    function automatic bit in_window(input int x, input int y);
        return x >= 0 && x <= X_MAX && y >= 0 && y <= Y_MAX;
    endfunction

    function automatic bit on_border(input int x, input int y);
        return x == 0 || x == X_MAX || y == 0 || y == Y_MAX;
    endfunction

    task automatic random_vertices(inout obj_t o, input int xlo, input int xhi,
                                   input int ylo, input int yhi);
        o.x0 = rand_coord(xlo, xhi);
        o.y0 = rand_coord(ylo, yhi);
        o.x1 = rand_coord(xlo, xhi);
        o.y1 = rand_coord(ylo, yhi);
        o.x2 = rand_coord(xlo, xhi);
        o.y2 = rand_coord(ylo, yhi);
        o.x3 = rand_coord(xlo, xhi);
        o.y3 = rand_coord(ylo, yhi);
    endtask

    // edges close back on v0 and a point gives one line from v0 to itself
    task automatic expect_edges(input obj_t o);
        coord_t vx [4];
        coord_t vy [4];
        line_t  l;
        int     n;
        int     b;
        vx = '{o.x0, o.x1, o.x2, o.x3};
        vy = '{o.y0, o.y1, o.y2, o.y3};
        case (o.kind)
            OBJ_TRI:  n = 3;
            OBJ_QUAD: n = 4;
            default:  n = 1;
        endcase
        for (int e = 0; e < n; e++) begin
            b = (o.kind == OBJ_POINT) ? 0 : (e + 1) % ((o.kind == OBJ_LINE) ? 2 : n);
            l.x0    = vx[e];
            l.y0    = vy[e];
            l.x1    = vx[b];
            l.y1    = vy[b];
            l.color = o.color;
            exp_q.push_back(l);
        end
    endtask

    task automatic fill_memory(input logic [NUM_SLOTS-1:0] m, input expect_e how, input bit mixed);
        obj_t o;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            o       = '0;
            o.color = color_t'($urandom);
            o.kind  = mixed ? obj_type_e'($urandom % 4) : obj_type_e'(s % 4);
            if (how == EXPECT_EXACT) begin
                random_vertices(o, 0, X_MAX, 0, Y_MAX);
            end else if (how == EXPECT_NONE) begin
                case (s % 4)    // whole object beyond one window edge
                    0:       random_vertices(o, -300, 900, Y_MAX + 1, Y_MAX + 400);
                    1:       random_vertices(o, -300, 900, -400, -1);
                    2:       random_vertices(o, X_MAX + 1, X_MAX + 400, -300, 700);
                    default: random_vertices(o, -400, -1, -300, 700);
                endcase
            end else begin
                o.kind = OBJ_LINE;
                random_vertices(o, 0, X_MAX, 0, Y_MAX);
                do begin
                    o.x1 = rand_coord(-1000, 1640);
                    o.y1 = rand_coord(-1000, 1480);
                end while (in_window(o.x1, o.y1));
                if ($urandom % 2) begin
                    {o.x0, o.y0, o.x1, o.y1} = {o.x1, o.y1, o.x0, o.y0};
                end
            end
            obj_mem[s] = o;
            if (m[s] && how != EXPECT_NONE) expect_edges(o);
        end
    endtask

    task automatic run_scan(input logic [NUM_SLOTS-1:0] m, input expect_e how, input bit repulse);
        @(posedge clk);
        #1;
        mode    = how;
        obj_map = m;
        start   = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        assert (busy) else abort_run("busy did not rise after start");
        if (repulse) begin
            while (!(mem_rd && mem_addr == slot_t'(NUM_SLOTS - 1))) begin
                @(posedge clk);
                #1;
            end
            // fetcher is idle by now while the engine still drains the FIFO
            repeat (7) @(posedge clk);
            #1;
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        while (busy) begin
            @(posedge clk);
            #1;
        end
        assert (exp_q.size() == 0)
            else abort_run($sformatf("busy fell with %0d lines not emitted", exp_q.size()));
    endtask

    task automatic check_end(input string tag, input coord_t gx, input coord_t gy,
                             input coord_t sx, input coord_t sy);
        assert (in_window(gx, gy))
            else abort_run($sformatf("endpoint %s at (%0d,%0d) is outside the window",
                                     tag, gx, gy));
        if (in_window(sx, sy)) begin
            assert (gx == sx) else mismatch({"line_out.x", tag}, gx, sx);
            assert (gy == sy) else mismatch({"line_out.y", tag}, gy, sy);
        end else begin
            assert (on_border(gx, gy))
                else abort_run($sformatf("endpoint %s moved to (%0d,%0d), not on the boundary",
                                         tag, gx, gy));
        end
    endtask

    // object memory answering two cycles after mem_rd
    always @(negedge clk) begin
        slot_t a;
        if (rst_n && mem_rd) begin
            a = mem_addr;
            @(posedge clk);
            @(posedge clk);
            #1;
            obj = obj_mem[a];
            @(posedge clk);
            #1;
            obj = '0;
        end
    end

    always @(negedge clk) begin
        line_t want;
        if (rst_n && line_vld) begin
            assert (mode != EXPECT_NONE)
                else abort_run("line emitted in a scan of rejected objects");
            assert (exp_q.size() > 0) else abort_run("line emitted with none left to expect");
            want = exp_q.pop_front();
            if (mode == EXPECT_EXACT) begin
                assert (line_out == want) else mismatch("line_out", line_out, want);
            end else begin
                assert (line_out.color == want.color)
                    else mismatch("line_out.color", line_out.color, want.color);
                check_end("0", line_out.x0, line_out.y0, want.x0, want.y0);
                check_end("1", line_out.x1, line_out.y1, want.x1, want.y1);
            end
        end
        assert (clip_unit_i.assert_i.err_cnt == 0)
            else abort_run("a bound protocol assertion failed");
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        assert (cycles < TIMEOUT) else abort_run("timeout, the scans did not finish");
    end

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        start   = 1'b0;
        obj_map = '0;
        obj     = '0;
        mode    = EXPECT_NONE;
        cycles  = 0;
        void'($urandom(32'h6f5e_a866));
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (!mem_rd && !line_vld && !busy) else abort_run("outputs not idle after reset");

        map = $urandom | 32'h0000_000f;     // sparse map where slots 0 to 3 give every kind
        fill_memory(map, EXPECT_EXACT, 1'b0);
        run_scan(map, EXPECT_EXACT, 1'b0);
        fill_memory('1, EXPECT_EXACT, 1'b1);  // dense map so the fetch stalls on room
        run_scan('1, EXPECT_EXACT, 1'b1);
        fill_memory('1, EXPECT_NONE, 1'b1);
        run_scan('1, EXPECT_NONE, 1'b0);
        fill_memory('1, EXPECT_CLIPPED, 1'b0);
        run_scan('1, EXPECT_CLIPPED, 1'b0);
        map = $urandom;
        fill_memory(map, EXPECT_CLIPPED, 1'b0);
        run_scan(map, EXPECT_CLIPPED, 1'b0);

        if (clip_unit_i.assert_i.err_cnt == 0 && exp_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("errors left at the end of the run");
        end
    end

endmodule

/* testbench/clip_unit_assert.sv */
`timescale 1ns/1ps

module clip_unit_assert import vector_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 start,
    input logic [NUM_SLOTS-1:0] obj_map,
    input slot_t                mem_addr,
    input logic                 mem_rd,
    input logic                 line_vld,
    input logic                 busy
);

    int    err_cnt = 0;    // failed assertions so far
    logic  read_seen;      // some slot was read in this scan
    slot_t last_read;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_seen <= 1'b0;
            last_read <= '0;
        end else if (start && !busy) begin
            read_seen <= 1'b0;              // a fresh scan begins
        end else if (mem_rd) begin
            read_seen <= 1'b1;
            last_read <= mem_addr;
        end
    end

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_rd && !line_vld && !busy)
        else begin
            err_cnt = err_cnt + 1;
            $error("mem_rd, line_vld or busy high during reset");
        end

    read_set_slot: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd |-> obj_map[mem_addr])
        else begin
            err_cnt = err_cnt + 1;
            $error("read of slot %0d whose map bit is clear", mem_addr);
        end

    // strictly rising addresses also rule out a second read of a slot
    read_ascending: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd && read_seen |-> mem_addr > last_read)
        else begin
            err_cnt = err_cnt + 1;
            $error("slot %0d read after slot %0d in one scan", mem_addr, last_read);
        end

    read_while_busy: assert property (@(posedge clk) disable iff (!rst_n) mem_rd |-> busy)
        else begin
            err_cnt = err_cnt + 1;
            $error("mem_rd while busy is low");
        end

    line_while_busy: assert property (@(posedge clk) disable iff (!rst_n) line_vld |-> busy)
        else begin
            err_cnt = err_cnt + 1;
            $error("line_vld while busy is low");
        end

endmodule

bind clip_unit clip_unit_assert assert_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .obj_map  (obj_map),
    .mem_addr (mem_addr),
    .mem_rd   (mem_rd),
    .line_vld (line_vld),
    .busy     (busy)
);

/* hdl/clip_unit.sv */
`timescale 1ns/1ps

module clip_unit import vector_pkg::*; #(
    parameter coord_t X_MAX      = 640,
    parameter coord_t Y_MAX      = 480,
    parameter int     FIFO_DEPTH = 16     // at least 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [NUM_SLOTS-1:0] obj_map,
    output slot_t                mem_addr,
    output logic                 mem_rd,
    input  obj_t                 obj,       // valid two cycles after mem_rd
    output line_t                line_out,
    output logic                 line_vld,
    output logic                 busy
);

    logic  push;
    line_t push_line;
    logic  room;
    logic  pop;
    logic  empty;
    line_t head;
    logic  scan_busy;
    logic  eng_idle;
    logic  start_ok;

    assign start_ok = start && !busy;   // no restart mid scan
    assign busy     = scan_busy || !empty || !eng_idle;

    object_fetch fetch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start_ok),
        .obj_map   (obj_map),
        .obj       (obj),
        .room      (room),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .push      (push),
        .push_line (push_line),
        .scan_busy (scan_busy)
    );

    line_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_line (push_line),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .room      (room)
    );

    clip_engine #(
        .X_MAX (X_MAX),
        .Y_MAX (Y_MAX)
    ) engine_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .empty    (empty),
        .head     (head),
        .pop      (pop),
        .line_out (line_out),
        .line_vld (line_vld),
        .idle     (eng_idle)
    );

endmodule

/* hdl/clip_engine.sv */
`timescale 1ns/1ps

module clip_engine import vector_pkg::*, clip_pkg::*; #(
    parameter coord_t X_MAX = 640,
    parameter coord_t Y_MAX = 480
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  empty,
    input  line_t head,
    output logic  pop,
    output line_t line_out,
    output logic  line_vld,
    output logic  idle
);

    clip_state_e        state;
    clip_state_e        state_nxt;
    line_t              work;       // line being clipped
    outcode_t           oc0;
    outcode_t           oc1;
    outcode_t           oc_sel;
    logic               sel_pt1;    // endpoint 1 is the one moved
    edge_e              sel_edge;
    logic               y_edge;
    coord_t             bound;
    coord_t             xa, ya;     // moved endpoint
    coord_t             xb, yb;     // fixed endpoint
    coord_t             along_a, along_b;
    coord_t             across_a, across_b;
    coord_t             new_along;
    coord_t             upd_x, upd_y;
    logic               accept;
    logic               reject;
    logic signed [31:0] div_num;
    coord_t             div_den;
    logic               div_go;
    logic               div_done;
    coord_t             div_q;

    function automatic outcode_t outcode_of(input coord_t x, input coord_t y);
        outcode_t oc;
        oc[OC_YMAX] = (y > Y_MAX);
        oc[OC_YMIN] = (y < 0);
        oc[OC_XMAX] = (x > X_MAX);
        oc[OC_XMIN] = (x < 0);
        return oc;
    endfunction

    assign accept = ((oc0 | oc1) == '0);
    assign reject = ((oc0 & oc1) != '0);

    // endpoint and edge choice, stable from DECIDE through UPDATE
    always_comb begin
        sel_pt1 = (oc0 == '0);
        oc_sel  = sel_pt1 ? oc1 : oc0;
        if (oc_sel[OC_YMAX])      sel_edge = EDGE_YMAX;
        else if (oc_sel[OC_YMIN]) sel_edge = EDGE_YMIN;
        else if (oc_sel[OC_XMAX]) sel_edge = EDGE_XMAX;
        else                      sel_edge = EDGE_XMIN;
        case (sel_edge)
            EDGE_YMAX: bound = Y_MAX;
            EDGE_XMAX: bound = X_MAX;
            default:   bound = '0;
        endcase
        y_edge = (sel_edge == EDGE_YMAX) || (sel_edge == EDGE_YMIN);

        xa = sel_pt1 ? work.x1 : work.x0;
        ya = sel_pt1 ? work.y1 : work.y0;
        xb = sel_pt1 ? work.x0 : work.x1;
        yb = sel_pt1 ? work.y0 : work.y1;

        // on a y edge x is interpolated, on an x edge y
        along_a  = y_edge ? xa : ya;
        along_b  = y_edge ? xb : yb;
        across_a = y_edge ? ya : xa;
        across_b = y_edge ? yb : xb;

        new_along = along_a + div_q;
        upd_x     = y_edge ? new_along : bound;
        upd_y     = y_edge ? bound : new_along;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (!empty) state_nxt = LOAD;
            LOAD:    state_nxt = DECIDE;
            DECIDE: begin
                if (accept)      state_nxt = EMIT;
                else if (reject) state_nxt = IDLE;   // dropped silently
                else             state_nxt = SETUP;
            end
            SETUP:   state_nxt = DIVIDE;
            DIVIDE:  if (div_done) state_nxt = UPDATE;
            UPDATE:  state_nxt = DECIDE;
            EMIT:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            div_go <= 1'b0;
        end else begin
            state  <= state_nxt;
            div_go <= (state == SETUP);     // operands are registered by then
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            work <= head;
        end
        if (state == LOAD) begin
            oc0 <= outcode_of(work.x0, work.y0);
            oc1 <= outcode_of(work.x1, work.y1);
        end
        if (state == SETUP) begin
            // evaluated at 32 bits so the differences do not wrap
            div_num <= (along_b - along_a) * (bound - across_a);
            div_den <= across_b - across_a;     // nonzero, the endpoints straddle the edge
        end
        if (state == UPDATE) begin
            if (sel_pt1) begin
                work.x1 <= upd_x;
                work.y1 <= upd_y;
                oc1     <= outcode_of(upd_x, upd_y);
            end else begin
                work.x0 <= upd_x;
                work.y0 <= upd_y;
                oc0     <= outcode_of(upd_x, upd_y);
            end
        end
    end

    seq_divider div_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .go       (div_go),
        .dividend (div_num),
        .divisor  (div_den),
        .quotient (div_q),
        .done     (div_done)
    );

    assign pop      = (state == IDLE) && !empty;
    assign line_out = work;
    assign line_vld = (state == EMIT);
    assign idle     = (state == IDLE);

endmodule

/* hdl/seq_divider.sv */
`timescale 1ns/1ps

module seq_divider import vector_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               go,
    input  logic signed [31:0] dividend,
    input  coord_t             divisor,
    output coord_t             quotient,
    output logic               done
);

    logic        run;
    logic [4:0]  step;
    logic [31:0] qr;        // dividend bits shift out at the top, quotient bits in at the bottom
    logic [15:0] rem;
    logic [15:0] dvs_mag;
    logic        neg;       // result sign
    logic [16:0] trial;
    logic        fits;

    assign trial = {rem, qr[31]};
    assign fits  = (trial >= {1'b0, dvs_mag});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run  <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                run  <= 1'b1;
                step <= '0;
            end else if (run) begin
                step <= step + 1'b1;
                if (step == 5'd31) begin    // last quotient bit this cycle
                    run  <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            qr      <= dividend[31] ? -dividend : dividend;
            rem     <= '0;
            dvs_mag <= divisor[15] ? -divisor : divisor;
            neg     <= dividend[31] ^ divisor[15];
        end else if (run) begin
            rem <= fits ? 16'(trial - {1'b0, dvs_mag}) : trial[15:0];
            qr  <= {qr[30:0], fits};
        end
    end

    // negating the magnitude truncates toward zero
    assign quotient = neg ? -coord_t'(qr[15:0]) : coord_t'(qr[15:0]);

endmodule

/* hdl/line_fifo.sv */
`timescale 1ns/1ps

module line_fifo import vector_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  line_t push_line,
    input  logic  pop,
    output line_t head,
    output logic  empty,
    output logic  room
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    line_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // wraps for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_pop = pop && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_line;   // fetcher only pushes with room
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)   wr_ptr <= ptr_next(wr_ptr);
            if (do_pop) rd_ptr <= ptr_next(rd_ptr);
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];                      // first word fall through
    assign empty = (count == '0);
    assign room  = (count <= CNT_W'(FIFO_DEPTH - 4)); // space for a quad

endmodule

/* hdl/object_fetch.sv */
`timescale 1ns/1ps

module object_fetch import vector_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [NUM_SLOTS-1:0] obj_map,
    input  obj_t                 obj,
    input  logic                 room,
    output slot_t                mem_addr,
    output logic                 mem_rd,
    output logic                 push,
    output line_t                push_line,
    output logic                 scan_busy
);

    typedef enum logic [1:0] {
        F_IDLE  = 2'd0,
        F_CHECK = 2'd1,
        F_WAIT  = 2'd2,
        F_PUSH  = 2'd3
    } fetch_state_e;

    fetch_state_e state;
    slot_t        slot;
    logic         rd_wait;     // set in the second cycle after mem_rd
    logic [1:0]   edge_cnt;
    logic [1:0]   last_edge;
    logic [1:0]   vb;          // end vertex of the current edge
    obj_t         obj_q;
    coord_t       vx [4];
    coord_t       vy [4];
    logic         slot_set;
    logic         last_slot;

    assign slot_set  = obj_map[slot];
    assign last_slot = (slot == slot_t'(NUM_SLOTS - 1));
    assign mem_addr  = slot;
    assign mem_rd    = (state == F_CHECK) && slot_set && room;  // room covers a whole quad
    assign push      = (state == F_PUSH);
    assign scan_busy = (state != F_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= F_IDLE;
            slot     <= '0;
            rd_wait  <= 1'b0;
            edge_cnt <= '0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (start) begin
                        slot  <= '0;
                        state <= F_CHECK;
                    end
                end
                F_CHECK: begin
                    if (!slot_set) begin
                        slot  <= slot + 1'b1;
                        state <= last_slot ? F_IDLE : F_CHECK;
                    end else if (room) begin
                        rd_wait <= 1'b0;
                        state   <= F_WAIT;
                    end
                end
                F_WAIT: begin
                    rd_wait <= 1'b1;
                    if (rd_wait) begin      // obj is on the bus now
                        edge_cnt <= '0;
                        state    <= F_PUSH;
                    end
                end
                F_PUSH: begin
                    edge_cnt <= edge_cnt + 1'b1;
                    if (edge_cnt == last_edge) begin
                        slot  <= slot + 1'b1;
                        state <= last_slot ? F_IDLE : F_CHECK;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_WAIT && rd_wait) begin
            obj_q <= obj;
        end
    end

    assign vx = '{obj_q.x0, obj_q.x1, obj_q.x2, obj_q.x3};
    assign vy = '{obj_q.y0, obj_q.y1, obj_q.y2, obj_q.y3};

    // edges per kind minus one
    always_comb begin
        case (obj_q.kind)
            OBJ_TRI:  last_edge = 2'd2;
            OBJ_QUAD: last_edge = 2'd3;
            default:  last_edge = 2'd0;
        endcase
    end

    // edge n runs from vertex n to the next one, closing back on v0
    always_comb begin
        case (obj_q.kind)
            OBJ_POINT: vb = 2'd0;   // degenerate line
            OBJ_LINE:  vb = 2'd1;
            default:   vb = (edge_cnt == last_edge) ? 2'd0 : edge_cnt + 2'd1;
        endcase
    end

    always_comb begin
        push_line.x0    = vx[edge_cnt];
        push_line.y0    = vy[edge_cnt];
        push_line.x1    = vx[vb];
        push_line.y1    = vy[vb];
        push_line.color = obj_q.color;
    end

endmodule

/* hdl/clip_pkg.sv */
package clip_pkg;

    // outcode bit positions
    localparam int OC_XMIN = 0;   // x below zero
    localparam int OC_XMAX = 1;   // x right of X_MAX
    localparam int OC_YMIN = 2;   // y below zero
    localparam int OC_YMAX = 3;   // y above Y_MAX

    typedef logic [3:0] outcode_t;

    // listed in the order the engine picks them
    typedef enum logic [1:0] {
        EDGE_YMAX = 2'd0,
        EDGE_YMIN = 2'd1,
        EDGE_XMAX = 2'd2,
        EDGE_XMIN = 2'd3
    } edge_e;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOAD   = 3'd1,
        DECIDE = 3'd2,
        SETUP  = 3'd3,
        DIVIDE = 3'd4,
        UPDATE = 3'd5,
        EMIT   = 3'd6
    } clip_state_e;

endpackage

/* hdl/vector_pkg.sv */
package vector_pkg;

    typedef logic signed [15:0] coord_t;   // screen coordinate, may lie off screen
    typedef logic [7:0]         color_t;   // colour index
    typedef logic [4:0]         slot_t;    // object slot number

    localparam int NUM_SLOTS = 32;

    typedef enum logic [1:0] {
        OBJ_POINT = 2'd0,
        OBJ_LINE  = 2'd1,
        OBJ_TRI   = 2'd2,
        OBJ_QUAD  = 2'd3
    } obj_type_e;

    // object memory word, x0 sits in bits [15:0]
    typedef struct packed {
        obj_type_e  kind;    // [143:142]
        logic [5:0] spare;   // [141:136] not used by the clipper
        color_t     color;   // [135:128]
        coord_t     y3;
        coord_t     x3;
        coord_t     y2;
        coord_t     x2;
        coord_t     y1;
        coord_t     x1;
        coord_t     y0;
        coord_t     x0;
    } obj_t;

    // one edge, x0 in the low word
    typedef struct packed {
        color_t color;
        coord_t y1;
        coord_t x1;
        coord_t y0;
        coord_t x0;
    } line_t;

endpackage
